//--- rtl/alu_pkg.sv
package alu_pkg;

    localparam int XLEN        = 64;
    localparam int TAG_W       = 4;
    localparam int QUEUE_DEPTH = 4;
    localparam int RES_CREDITS = 2;
    localparam int SHAMT_W     = 6;

    // counter and pointer widths derived from the sizes above
    localparam int QCNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam int QPTR_W = $clog2(QUEUE_DEPTH);
    localparam int RCNT_W = $clog2(RES_CREDITS + 1);
    localparam int ITER_W = $clog2(XLEN + 1);

    typedef logic [XLEN-1:0]   xlen_t;
    typedef logic [TAG_W-1:0]  tag_t;
    typedef logic [QCNT_W-1:0] qcnt_t;
    typedef logic [QPTR_W-1:0] qptr_t;
    typedef logic [RCNT_W-1:0] rcnt_t;
    typedef logic [ITER_W-1:0] iter_t;

    typedef enum logic [4:0] {
        ADD, SUB, PASS_A, PASS_B, XOR, OR, AND,
        SLL, SRL, SRA, SLT, SLTU, EQ, GE, GEU,
        MUL, DIV, DIVU, REM, REMU
    } alu_op_e;

    typedef enum logic {PC, RS1} sel_a_e;

    typedef enum logic [1:0] {IMM, RS2, CSR} sel_b_e;

    typedef enum logic [1:0] {IDLE, RUN, DONE} muldiv_state_e;

    // raw request as it arrives from the issuer
    typedef struct packed {
        alu_op_e op;
        sel_a_e  sel_a;
        sel_b_e  sel_b;
        logic    word;
        tag_t    tag;
        xlen_t   pc;
        xlen_t   rs1;
        xlen_t   rs2;
        xlen_t   csr;
        xlen_t   imm;
    } alu_req_t;

    // request with operands already selected
    typedef struct packed {
        alu_op_e op;
        logic    word;
        tag_t    tag;
        xlen_t   a;
        xlen_t   b;
    } exec_req_t;

    typedef struct packed {
        tag_t  tag;
        xlen_t value;
    } alu_res_t;

endpackage

//--- rtl/alu_issue.sv
`timescale 1ns/1ps

module alu_issue (
    input  logic                clk,
    input  logic                reset,
    input  logic                req_valid,
    input  alu_pkg::alu_req_t   req,
    input  logic                md_busy,
    input  logic                queue_credit,
    input  logic                md_credit,
    output logic                req_ready,
    output logic                fast_valid,
    output alu_pkg::exec_req_t  fast_req,
    output logic                md_valid,
    output alu_pkg::exec_req_t  md_req
);

    alu_pkg::exec_req_t exec;
    alu_pkg::qcnt_t     credits;
    logic               ready_en;
    logic               accept;
    logic               is_md;

    // operand selection
    always_comb begin
        exec.op   = req.op;
        exec.word = req.word;
        exec.tag  = req.tag;

        case (req.sel_a)
            alu_pkg::RS1: begin
                if (req.word) begin
                    exec.a = {{(alu_pkg::XLEN/2){1'b0}}, req.rs1[alu_pkg::XLEN/2-1:0]};
                end else begin
                    exec.a = req.rs1;
                end
            end
            default: exec.a = req.pc;
        endcase

        case (req.sel_b)
            alu_pkg::RS2: exec.b = req.rs2;
            alu_pkg::CSR: exec.b = req.csr;
            default:      exec.b = req.imm;
        endcase
    end

    // multiply and divide go to the iterative unit
    assign is_md = req.op inside {alu_pkg::MUL, alu_pkg::DIV, alu_pkg::DIVU,
                                  alu_pkg::REM, alu_pkg::REMU};

    // stall while the iterative unit runs or the merge queue has no room
    assign req_ready = ready_en && !md_busy && (credits != '0);
    assign accept    = req_valid && req_ready;

    assign fast_valid = accept && !is_md;
    assign md_valid   = accept && is_md;
    assign fast_req   = exec;
    assign md_req     = exec;

    always_ff @(posedge clk) begin
        if (reset) begin
            ready_en <= 1'b0;
            credits  <= alu_pkg::qcnt_t'(alu_pkg::QUEUE_DEPTH);
        end else begin
            ready_en <= 1'b1;
            // one credit per accepted request, back on pop or on abort
            credits  <= credits
                        + alu_pkg::qcnt_t'(queue_credit)
                        + alu_pkg::qcnt_t'(md_credit)
                        - alu_pkg::qcnt_t'(accept);
        end
    end

endmodule

//--- rtl/alu_fast.sv
`timescale 1ns/1ps

module alu_fast (
    input  logic                clk,
    input  logic                reset,
    input  logic                fast_valid,
    input  alu_pkg::exec_req_t  fast_req,
    output logic                fast_res_valid,
    output alu_pkg::alu_res_t   fast_res
);

    alu_pkg::xlen_t              a;
    alu_pkg::xlen_t              b;
    alu_pkg::xlen_t              value;
    logic [alu_pkg::SHAMT_W-1:0] shamt;

    always_comb begin
        a     = fast_req.a;
        b     = fast_req.b;
        shamt = b[alu_pkg::SHAMT_W-1:0];

        case (fast_req.op)
            alu_pkg::ADD:    value = a + b;
            alu_pkg::SUB:    value = a - b;
            alu_pkg::PASS_A: value = a;
            alu_pkg::PASS_B: value = b;
            alu_pkg::XOR:    value = a ^ b;
            alu_pkg::OR:     value = a | b;
            alu_pkg::AND:    value = a & b;
            alu_pkg::SLL:    value = a << shamt;
            alu_pkg::SRL:    value = a >> shamt;
            alu_pkg::SRA: begin
                // word form shifts the low half, upper half stays zero
                if (fast_req.word) begin
                    value = {{(alu_pkg::XLEN/2){1'b0}},
                             $signed(a[alu_pkg::XLEN/2-1:0]) >>> shamt};
                end else begin
                    value = $signed(a) >>> shamt;
                end
            end
            alu_pkg::SLT:    value = alu_pkg::xlen_t'($signed(a) < $signed(b));
            alu_pkg::SLTU:   value = alu_pkg::xlen_t'(a < b);
            alu_pkg::EQ:     value = alu_pkg::xlen_t'(a == b);
            alu_pkg::GE:     value = alu_pkg::xlen_t'($signed(a) >= $signed(b));
            alu_pkg::GEU:    value = alu_pkg::xlen_t'(a >= b);
            default:         value = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fast_res_valid <= 1'b0;
        end else begin
            fast_res_valid <= fast_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fast_valid) begin
            fast_res.tag   <= fast_req.tag;
            fast_res.value <= value;
        end
    end

endmodule

//--- rtl/alu_muldiv.sv
`timescale 1ns/1ps

module alu_muldiv (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,
    input  logic                md_valid,
    input  alu_pkg::exec_req_t  md_req,
    output logic                md_busy,
    output logic                md_credit,
    output logic                md_res_valid,
    output alu_pkg::alu_res_t   md_res
);

    alu_pkg::muldiv_state_e state;
    alu_pkg::iter_t         iter;
    alu_pkg::exec_req_t     req_q;

    // mul: acc is the product, opa the shifted multiplicand, opb the multiplier
    // div: acc is the remainder, opa dividend then quotient, opb the divisor
    alu_pkg::xlen_t acc;
    alu_pkg::xlen_t opa;
    alu_pkg::xlen_t opb;

    logic                   is_mul;
    logic                   is_signed;
    logic                   want_quo;
    logic                   neg_a;
    logic                   neg_b;
    logic [alu_pkg::XLEN:0] rem_sh;
    logic [alu_pkg::XLEN:0] diff;
    alu_pkg::xlen_t         quo;
    alu_pkg::xlen_t         rem;
    alu_pkg::xlen_t         result;

    assign md_busy = (state != alu_pkg::IDLE);

    always_comb begin
        is_mul    = (req_q.op == alu_pkg::MUL);
        is_signed = (req_q.op == alu_pkg::DIV) || (req_q.op == alu_pkg::REM);
        want_quo  = (req_q.op == alu_pkg::DIV) || (req_q.op == alu_pkg::DIVU);
        neg_a     = is_signed && req_q.a[alu_pkg::XLEN-1];
        neg_b     = is_signed && req_q.b[alu_pkg::XLEN-1];

        // one restoring step
        rem_sh = {acc, opa[alu_pkg::XLEN-1]};
        diff   = rem_sh - {1'b0, opb};

        // sign fix; most negative by minus one comes out right on its own
        quo = (neg_a ^ neg_b) ? -opa : opa;
        rem = neg_a ? -acc : acc;

        if (is_mul) begin
            result = acc;
        end else if (req_q.b == '0) begin
            result = want_quo ? '1 : req_q.a;
        end else begin
            result = want_quo ? quo : rem;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= alu_pkg::IDLE;
            iter         <= '0;
            md_res_valid <= 1'b0;
            md_credit    <= 1'b0;
        end else begin
            md_res_valid <= 1'b0;
            md_credit    <= 1'b0;
            if (flush && state != alu_pkg::IDLE) begin
                // abort, the issue stage gets its credit back
                state     <= alu_pkg::IDLE;
                md_credit <= 1'b1;
            end else begin
                case (state)
                    alu_pkg::IDLE: begin
                        if (md_valid) begin
                            state <= alu_pkg::RUN;
                            iter  <= '0;
                        end
                    end
                    alu_pkg::RUN: begin
                        iter <= iter + 1'b1;
                        if (iter == alu_pkg::iter_t'(alu_pkg::XLEN)) begin
                            state <= alu_pkg::DONE;
                        end
                    end
                    alu_pkg::DONE: begin
                        state        <= alu_pkg::IDLE;
                        md_res_valid <= 1'b1;
                    end
                    default: state <= alu_pkg::IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == alu_pkg::IDLE && md_valid) begin
            req_q <= md_req;
        end

        if (state == alu_pkg::RUN) begin
            if (iter == '0) begin
                // load cycle, divide works on magnitudes
                acc <= '0;
                opa <= neg_a ? -req_q.a : req_q.a;
                opb <= neg_b ? -req_q.b : req_q.b;
            end else if (is_mul) begin
                if (opb[0]) begin
                    acc <= acc + opa;
                end
                opa <= opa << 1;
                opb <= opb >> 1;
            end else if (!diff[alu_pkg::XLEN]) begin
                acc <= diff[alu_pkg::XLEN-1:0];
                opa <= {opa[alu_pkg::XLEN-2:0], 1'b1};
            end else begin
                acc <= rem_sh[alu_pkg::XLEN-1:0];
                opa <= {opa[alu_pkg::XLEN-2:0], 1'b0};
            end
        end

        if (state == alu_pkg::DONE) begin
            md_res.tag   <= req_q.tag;
            md_res.value <= result;
        end
    end

endmodule

//--- rtl/alu_result_merge.sv
`timescale 1ns/1ps

module alu_result_merge (
    input  logic               clk,
    input  logic               reset,
    input  logic               fast_res_valid,
    input  alu_pkg::alu_res_t  fast_res,
    input  logic               md_res_valid,
    input  alu_pkg::alu_res_t  md_res,
    input  logic               res_credit,
    output logic               queue_credit,
    output logic               res_valid,
    output alu_pkg::alu_res_t  res
);

    alu_pkg::alu_res_t mem [alu_pkg::QUEUE_DEPTH];
    alu_pkg::qptr_t    wr_ptr;
    alu_pkg::qptr_t    rd_ptr;
    alu_pkg::qcnt_t    count;
    alu_pkg::rcnt_t    credits;
    alu_pkg::alu_res_t push_data;
    logic              push;
    logic              pop;

    // the two paths are never valid together
    assign push      = fast_res_valid || md_res_valid;
    assign push_data = md_res_valid ? md_res : fast_res;

    // send whenever something is queued and downstream has room
    assign res_valid = (count != '0) && (credits != '0);
    assign pop       = res_valid;
    assign res       = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            credits      <= alu_pkg::rcnt_t'(alu_pkg::RES_CREDITS);
            queue_credit <= 1'b0;
        end else begin
            // pointers wrap on their own, depth is a power of two
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count        <= count + alu_pkg::qcnt_t'(push) - alu_pkg::qcnt_t'(pop);
            credits      <= credits + alu_pkg::rcnt_t'(res_credit) - alu_pkg::rcnt_t'(pop);
            queue_credit <= pop;
        end
    end

endmodule

//--- rtl/alu_top.sv
`timescale 1ns/1ps

module alu_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               flush,
    input  logic               req_valid,
    input  alu_pkg::alu_req_t  req,
    input  logic               res_credit,
    output logic               req_ready,
    output logic               res_valid,
    output alu_pkg::alu_res_t  res
);

    logic               fast_valid;
    alu_pkg::exec_req_t fast_req;
    logic               md_valid;
    alu_pkg::exec_req_t md_req;
    logic               md_busy;
    logic               md_credit;
    logic               queue_credit;
    logic               fast_res_valid;
    alu_pkg::alu_res_t  fast_res;
    logic               md_res_valid;
    alu_pkg::alu_res_t  md_res;

    alu_issue i_issue (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .req          (req),
        .md_busy      (md_busy),
        .queue_credit (queue_credit),
        .md_credit    (md_credit),
        .req_ready    (req_ready),
        .fast_valid   (fast_valid),
        .fast_req     (fast_req),
        .md_valid     (md_valid),
        .md_req       (md_req)
    );

    alu_fast i_fast (
        .clk            (clk),
        .reset          (reset),
        .fast_valid     (fast_valid),
        .fast_req       (fast_req),
        .fast_res_valid (fast_res_valid),
        .fast_res       (fast_res)
    );

    alu_muldiv i_muldiv (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .md_valid     (md_valid),
        .md_req       (md_req),
        .md_busy      (md_busy),
        .md_credit    (md_credit),
        .md_res_valid (md_res_valid),
        .md_res       (md_res)
    );

    alu_result_merge i_merge (
        .clk            (clk),
        .reset          (reset),
        .fast_res_valid (fast_res_valid),
        .fast_res       (fast_res),
        .md_res_valid   (md_res_valid),
        .md_res         (md_res),
        .res_credit     (res_credit),
        .queue_credit   (queue_credit),
        .res_valid      (res_valid),
        .res            (res)
    );

endmodule

//--- tests/alu_tb.sv
`timescale 1ns/1ps

module alu_tb;

    localparam int             TIMEOUT   = 2000;
    localparam alu_pkg::tag_t  FLUSH_TAG = 4'hf;
    localparam alu_pkg::xlen_t MIN_NEG   = 64'h8000_0000_0000_0000;

    logic              clk;
    logic              reset;
    logic              flush;
    logic              req_valid;
    alu_pkg::alu_req_t req;
    logic              res_credit;
    logic              req_ready;
    logic              res_valid;
    alu_pkg::alu_res_t res;

    // expected results in issue order
    alu_pkg::alu_res_t exp_q[$];
    int                owed         = 0;
    int                dut_credits  = alu_pkg::RES_CREDITS;
    int                res_count    = 0;
    bit                hold_credits = 0;
    alu_pkg::tag_t     next_tag     = '0;

    alu_top i_dut (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .req_valid  (req_valid),
        .req        (req),
        .res_credit (res_credit),
        .req_ready  (req_ready),
        .res_valid  (res_valid),
        .res        (res)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run();
        $display("Errors found");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        abort_run();
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    // expected value from the operation rules
    function automatic alu_pkg::xlen_t alu_ref(input alu_pkg::alu_req_t r);
        alu_pkg::xlen_t     a;
        alu_pkg::xlen_t     b;
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [31:0] lo;
        logic [5:0]         sh;
        alu_pkg::xlen_t     v;
        if (r.sel_a == alu_pkg::PC) a = r.pc;
        else if (r.word) a = {32'h0, r.rs1[31:0]};
        else a = r.rs1;
        if (r.sel_b == alu_pkg::RS2) b = r.rs2;
        else if (r.sel_b == alu_pkg::CSR) b = r.csr;
        else b = r.imm;
        sa = a;
        sb = b;
        lo = a[31:0];
        sh = b[5:0];
        case (r.op)
            alu_pkg::ADD:    v = a + b;
            alu_pkg::SUB:    v = a - b;
            alu_pkg::PASS_A: v = a;
            alu_pkg::PASS_B: v = b;
            alu_pkg::XOR:    v = a ^ b;
            alu_pkg::OR:     v = a | b;
            alu_pkg::AND:    v = a & b;
            alu_pkg::SLL:    v = a << sh;
            alu_pkg::SRL:    v = a >> sh;
            alu_pkg::SRA: begin
                if (r.word) v = {32'h0, lo >>> sh};
                else v = sa >>> sh;
            end
            alu_pkg::SLT:    v = (sa < sb) ? 64'd1 : 64'd0;
            alu_pkg::SLTU:   v = (a < b) ? 64'd1 : 64'd0;
            alu_pkg::EQ:     v = (a == b) ? 64'd1 : 64'd0;
            alu_pkg::GE:     v = (sa >= sb) ? 64'd1 : 64'd0;
            alu_pkg::GEU:    v = (a >= b) ? 64'd1 : 64'd0;
            alu_pkg::MUL:    v = a * b;
            alu_pkg::DIVU:   v = (b == 0) ? '1 : a / b;
            alu_pkg::REMU:   v = (b == 0) ? a : a % b;
            alu_pkg::DIV: begin
                if (b == 0) v = '1;
                else if (a == MIN_NEG && b == '1) v = a;
                else v = sa / sb;
            end
            alu_pkg::REM: begin
                if (b == 0) v = a;
                else if (a == MIN_NEG && b == '1) v = '0;
                else v = sa % sb;
            end
            default:         v = '0;
        endcase
        return v;
    endfunction

    // corner values show up often
    function automatic alu_pkg::xlen_t pick_operand();
        case ($urandom_range(0, 7))
            0:       return '0;
            1:       return '1;
            2:       return MIN_NEG;
            3:       return 64'd1;
            default: return {$urandom, $urandom};
        endcase
    endfunction

    // tags cycle through 0..14 and 15 marks flushed ops
    function automatic alu_pkg::alu_req_t make_req(input int op);
        alu_pkg::alu_req_t r;
        r.op    = alu_pkg::alu_op_e'(op);
        r.sel_a = alu_pkg::sel_a_e'($urandom_range(0, 1));
        r.sel_b = alu_pkg::sel_b_e'($urandom_range(0, 2));
        r.word  = $urandom_range(0, 1);
        r.tag   = next_tag;
        r.pc    = pick_operand();
        r.rs1   = pick_operand();
        r.rs2   = pick_operand();
        r.csr   = pick_operand();
        r.imm   = pick_operand();
        next_tag = (next_tag == 4'he) ? '0 : next_tag + 1'b1;
        return r;
    endfunction

    // starts and returns on a falling edge
    task automatic send(input alu_pkg::alu_req_t r, input bit watch_busy);
        int n;
        n = 0;
        req_valid = 1'b1;
        req       = r;
        @(posedge clk);
        while (!req_ready) begin
            n++;
            if (n > TIMEOUT) report_error("request was never accepted");
            @(posedge clk);
        end
        exp_q.push_back({r.tag, alu_ref(r)});
        @(negedge clk);
        req_valid = 1'b0;
        if (watch_busy && r.op inside {alu_pkg::MUL, alu_pkg::DIV, alu_pkg::DIVU,
                                       alu_pkg::REM, alu_pkg::REMU}) begin
            repeat (alu_pkg::XLEN + 2) begin
                @(posedge clk);
                check("req_ready", req_ready, 1'b0);
            end
            @(negedge clk);
        end
    endtask

    task automatic wait_ready(input logic level);
        int n;
        n = 0;
        @(posedge clk);
        while (req_ready !== level) begin
            n++;
            if (n > TIMEOUT) report_error($sformatf("req_ready never went to %0b", level));
            @(posedge clk);
        end
        @(negedge clk);
    endtask

    // all results out and all credits back
    task automatic wait_drained();
        int n;
        n = 0;
        @(negedge clk);
        while (exp_q.size() != 0 || dut_credits != alu_pkg::RES_CREDITS) begin
            n++;
            if (n > TIMEOUT) report_error("pending results did not drain");
            @(negedge clk);
        end
    endtask

    // compare process that also models the downstream credit count
    initial begin
        alu_pkg::alu_res_t exp;
        forever begin
            @(posedge clk);
            if (!reset) begin
                if (res_valid) begin
                    if (dut_credits == 0) report_error("result sent without a credit");
                    if (res.tag == FLUSH_TAG) report_error("flushed operation gave a result");
                    if (exp_q.size() == 0) report_error("result with no request pending");
                    exp = exp_q.pop_front();
                    check("res.tag", res.tag, exp.tag);
                    check("res.value", res.value, exp.value);
                    dut_credits--;
                    owed++;
                    res_count++;
                end
                if (res_credit) dut_credits++;
            end
        end
    end

    // downstream returns credits after a random delay
    initial begin
        forever begin
            @(negedge clk);
            if (!hold_credits && owed > 0) begin
                repeat ($urandom_range(0, 3)) @(negedge clk);
                res_credit = 1'b1;
                owed--;
                @(negedge clk);
                res_credit = 1'b0;
            end
        end
    end

    initial begin
        alu_pkg::alu_req_t r;
        int                base;
        void'($urandom(32'hef32_fd29));
        reset      = 1'b1;
        flush      = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        res_credit = 1'b0;
        repeat (4) @(posedge clk);
        check("req_ready", req_ready, 1'b0);
        check("res_valid", res_valid, 1'b0);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check("req_ready", req_ready, 1'b1);
        check("res_valid", res_valid, 1'b0);

        // random single-cycle operations
        repeat (60) begin
            send(make_req($urandom_range(0, 14)), 1'b0);
            repeat ($urandom_range(0, 2)) @(negedge clk);
        end
        wait_drained();

        // multiply and divide corners plus random operands
        for (int op = 15; op <= 19; op++) begin
            for (int k = 0; k < 4; k++) begin
                r       = make_req(op);
                r.sel_a = alu_pkg::RS1;
                r.sel_b = alu_pkg::RS2;
                r.word  = 1'b0;
                case (k)
                    0: r.rs2 = '0;
                    1: begin
                        r.rs1 = MIN_NEG;
                        r.rs2 = '1;
                    end
                    2: r.rs1 = '0;
                    default: ;
                endcase
                send(r, 1'b1);
            end
            repeat (3) send(make_req(op), 1'b1);
        end
        wait_drained();

        // mixed traffic
        repeat (40) begin
            if ($urandom_range(0, 3) == 0) send(make_req($urandom_range(15, 19)), 1'b1);
            else send(make_req($urandom_range(0, 14)), 1'b0);
        end
        wait_drained();

        // withheld credits fill the queue and the issue credits
        hold_credits = 1'b1;
        base         = res_count;
        repeat (alu_pkg::QUEUE_DEPTH + alu_pkg::RES_CREDITS) begin
            send(make_req($urandom_range(0, 14)), 1'b0);
        end
        wait_ready(1'b0);
        repeat (10) @(negedge clk);
        check("results while credits held", res_count - base, alu_pkg::RES_CREDITS);
        check("req_ready", req_ready, 1'b0);
        hold_credits = 1'b0;
        wait_drained();

        // flush an op in flight and carry on
        repeat (3) begin
            r     = make_req($urandom_range(15, 19));
            r.tag = FLUSH_TAG;
            send(r, 1'b0);
            repeat ($urandom_range(1, 60)) @(negedge clk);
            flush = 1'b1;
            exp_q.delete(exp_q.size() - 1);
            @(negedge clk);
            flush = 1'b0;
            wait_ready(1'b1);
            repeat (4) send(make_req($urandom_range(0, 19)), 1'b1);
        end
        wait_drained();
        repeat (20) @(negedge clk);

        $display("No errors");
        $finish;
    end

endmodule

//--- filelist.f
rtl/alu_pkg.sv
rtl/alu_issue.sv
rtl/alu_fast.sv
rtl/alu_muldiv.sv
rtl/alu_result_merge.sv
rtl/alu_top.sv
tests/alu_tb.sv
